/* src/pdp8Pkg.sv */
// Word type, instruction field positions and phase constants for the OPR unit
`default_nettype none

package pdp8Pkg;

  // Word size and the word type used for AC, MQ, PC and the bus
  localparam int wordW = 12;
  typedef logic [wordW-1:0] word_t;

  // Phase sequencer
  localparam int phaseCount = 6;
  localparam int phaseW = 3;

  // Opcode field sits in PDP-8 bits 0..2
  localparam int opcodeW = 3;
  localparam logic [opcodeW-1:0] opcodeOpr = 3'd7;

  // Field bits use PDP-8 numbering, bit 0 is the MSB
  localparam int bitGroup = 3;
  localparam int bitGroup3 = 11;

  // Group 1
  localparam int bitCla = 4;
  localparam int bitCll = 5;
  localparam int bitCma = 6;
  localparam int bitCml = 7;
  localparam int bitRar = 8;
  localparam int bitRal = 9;
  localparam int bitTwice = 10;
  localparam int bitIac = 11;

  // Group 2
  localparam int bitCla2 = 4;
  localparam int bitSma = 5;
  localparam int bitSza = 6;
  localparam int bitSnl = 7;
  localparam int bitRev = 8;

  // Group 3
  localparam int bitMqa = 5;
  localparam int bitSca = 6;
  localparam int bitMql = 7;

  // Group 1 field is bits 5..11, group 2 field is bits 4..8
  localparam int g1FieldW = 7;
  localparam int g2FieldW = 5;

  // Pick one bit of a word by its PDP-8 bit number
  function automatic logic fieldBit(word_t w, int unsigned n);
    return w[wordW-1-n];
  endfunction

endpackage

`default_nettype wire

/* src/group1Logic.sv */
// Group 1 complement, increment and rotate of link and AC
`timescale 1ns/1ps
`default_nettype none

module group1Logic import pdp8Pkg::*; (
  input  word_t acIn,
  input  logic linkInBit,
  input  logic [g1FieldW-1:0] g1Field,
  input  logic apply,
  output word_t acOut,
  output logic linkOut
);

  // Link sits above AC as one 13-bit value
  logic [wordW:0] lac;
  logic cll;
  logic cma;
  logic cml;
  logic rar;
  logic ral;
  logic twice;
  logic iac;

  // Field holds PDP-8 bits 5..11 in its low end
  assign cll = g1Field[wordW-1-bitCll];
  assign cma = g1Field[wordW-1-bitCma];
  assign cml = g1Field[wordW-1-bitCml];
  assign rar = g1Field[wordW-1-bitRar];
  assign ral = g1Field[wordW-1-bitRal];
  assign twice = g1Field[wordW-1-bitTwice];
  assign iac = g1Field[wordW-1-bitIac];

  // CLA already arrives as a zero acIn from the datapath
  always_comb begin
    lac = {linkInBit, acIn};
    if (apply) begin
      if (cll) begin
        lac[wordW] = 1'b0;
      end
      if (cma) begin
        lac[wordW-1:0] = ~lac[wordW-1:0];
      end
      if (cml) begin
        lac[wordW] = ~lac[wordW];
      end
      // Carry out of AC toggles the link
      if (iac) begin
        lac = lac + 1'b1;
      end
      // Right wins if both rotate bits are set
      if (rar) begin
        lac = twice ? {lac[1:0], lac[wordW:2]} : {lac[0], lac[wordW:1]};
      end else if (ral) begin
        lac = twice ? {lac[wordW-2:0], lac[wordW:wordW-1]} : {lac[wordW-1:0], lac[wordW]};
      end
    end
  end

  assign linkOut = lac[wordW];
  assign acOut = lac[wordW-1:0];

endmodule

`default_nettype wire

/* src/oprSequencer.sv */
// OPR instruction latch, field decode and six-phase ck/stb generator
`timescale 1ns/1ps
`default_nettype none

module oprSequencer import pdp8Pkg::*; (
  input  logic ck,
  input  logic rstN,
  input  logic start,
  input  word_t instruction,
  input  logic done,
  output logic busy,
  output logic fault,
  output logic ck1, ck2, ck3, ck4, ck5, ck6,
  output logic stb1, stb2, stb3, stb4, stb5, stb6,
  output logic instOPR,
  output logic opr1,
  output logic opr2,
  output logic opr3,
  output logic oprCLA,
  output logic oprMQA,
  output logic oprMQL,
  output logic oprSCA,
  output logic [g1FieldW-1:0] g1Field,
  output logic [g2FieldW-1:0] g2Field
);

  word_t instLatch;
  logic [phaseW-1:0] phase;
  // Low in the first cycle of a phase, high in the strobe cycle
  logic half;
  logic [phaseCount-1:0] phaseLvl;
  logic [phaseCount-1:0] phaseStb;

  // Start is only taken while idle
  always_ff @(posedge ck) begin
    if (!rstN) begin
      busy <= 1'b0;
      phase <= '0;
      half <= 1'b0;
      fault <= 1'b0;
      instLatch <= '0;
    end else begin
      fault <= 1'b0;
      if (!busy) begin
        if (start) begin
          busy <= 1'b1;
          phase <= '0;
          half <= 1'b0;
          instLatch <= instruction;
        end
      end else if (done) begin
        // Decoder finished, drop out of the sequence
        busy <= 1'b0;
      end else if (half) begin
        half <= 1'b0;
        if (phase == phaseW'(phaseCount - 1)) begin
          // Ran past stb6 with no done, so the word was not executable
          busy <= 1'b0;
          fault <= 1'b1;
        end else begin
          phase <= phase + 1'b1;
        end
      end else begin
        half <= 1'b1;
      end
    end
  end

  // Phase levels span both cycles, strobes only the second
  always_comb begin
    for (int i = 0; i < phaseCount; i++) begin
      phaseLvl[i] = busy && (phase == phaseW'(i));
    end
  end
  assign phaseStb = phaseLvl & {phaseCount{half}};

  assign {ck6, ck5, ck4, ck3, ck2, ck1} = phaseLvl;
  assign {stb6, stb5, stb4, stb3, stb2, stb1} = phaseStb;

  // Field decode from the latched word
  assign instOPR = (instLatch[wordW-1 -: opcodeW] == opcodeOpr);
  assign opr1 = !fieldBit(instLatch, bitGroup);
  assign opr2 = fieldBit(instLatch, bitGroup) && !fieldBit(instLatch, bitGroup3);
  assign opr3 = fieldBit(instLatch, bitGroup) && fieldBit(instLatch, bitGroup3);
  assign oprCLA = fieldBit(instLatch, bitCla);
  assign oprMQA = fieldBit(instLatch, bitMqa);
  assign oprMQL = fieldBit(instLatch, bitMql);
  assign oprSCA = fieldBit(instLatch, bitSca);

  // Raw micro-op fields for the datapath
  assign g1Field = instLatch[g1FieldW-1:0];
  assign g2Field = instLatch[wordW-1-bitCla2 -: g2FieldW];

  // Phases never overlap
  phaseOneHot: assert property (@(posedge ck) disable iff (!rstN)
    $onehot0({ck6, ck5, ck4, ck3, ck2, ck1}));

endmodule

`default_nettype wire

/* src/instructionOpr.sv */
// OPR control decoder mapping instruction form and phase to register clocks and bus selects
`timescale 1ns/1ps
`default_nettype none

module instructionOpr (
  input  logic ck,
  input  logic ck1, ck2, ck3, ck4, ck5, ck6,
  input  logic stb1, stb2, stb3, stb4, stb5, stb6,
  input  logic doSkip,
  input  logic instOPR,
  input  logic opr1,
  input  logic opr2,
  input  logic opr3,
  input  logic oprCLA,
  input  logic oprMQA,
  input  logic oprMQL,
  input  logic oprSCA,
  output logic acCk,
  output logic cla,
  output logic done,
  output logic linkCk,
  output logic mqCk,
  output logic mq2orbus,
  output logic pcCk,
  output logic rot2ac,
  output logic mqTmpLatch,
  output logic mqTmpOE,
  output logic group1Apply
);

  logic op1;
  logic op2;
  logic base3;
  logic o3Nop;
  logic o3Cla;
  logic o3Mqa;
  logic o3Acl;
  logic o3Mql;
  logic o3Cam;
  logic o3Swp;
  logic o3ClaSwp;
  // Both swap forms share one phase pattern
  logic o3AnySwp;

  assign op1 = instOPR & opr1;
  assign op2 = instOPR & opr2;

  // SCA in any combination leaves every form unmatched and ends in fault
  assign base3 = instOPR & opr3 & !oprSCA;
  // 7401 NOP
  assign o3Nop = base3 & !oprCLA & !oprMQA & !oprMQL;
  // 7601 CLA
  assign o3Cla = base3 & oprCLA & !oprMQA & !oprMQL;
  // 7501 MQA, AC or MQ
  assign o3Mqa = base3 & !oprCLA & oprMQA & !oprMQL;
  // 7701 ACL, AC gets MQ
  assign o3Acl = base3 & oprCLA & oprMQA & !oprMQL;
  // 7421 MQL, MQ gets AC then AC cleared
  assign o3Mql = base3 & !oprCLA & !oprMQA & oprMQL;
  // 7621 CAM, clear both
  assign o3Cam = base3 & oprCLA & !oprMQA & oprMQL;
  // 7521 SWP
  assign o3Swp = base3 & !oprCLA & oprMQA & oprMQL;
  // 7721 CLA SWP, AC gets MQ and MQ cleared
  assign o3ClaSwp = base3 & oprCLA & oprMQA & oprMQL;
  assign o3AnySwp = o3Swp | o3ClaSwp;

  // Group 1 result onto the bus in phase 1 only
  assign group1Apply = op1 & ck1;

  assign rot2ac = (op1 & ck1)
                | (op2 & (ck1 | ck2))
                | ((o3Cla | o3Mqa | o3Acl) & ck1)
                | (o3Mql & (ck1 | ck2))
                | (o3Cam & ck1)
                | (o3AnySwp & (ck1 | ck2 | ck3));

  // Group 2 clears after the skip test has used the old AC
  // 7721 clears in phase 1 so the temporary latch captures zero
  assign cla = (op1 & oprCLA & ck1)
             | (op2 & oprCLA & ck2)
             | ((o3Cla | o3Acl | o3Cam) & ck1)
             | (o3Mql & ck2)
             | (o3Swp & (ck2 | ck3))
             | (o3ClaSwp & (ck1 | ck2 | ck3));

  assign acCk = (op1 & stb1)
              | (op2 & stb2)
              | ((o3Cla | o3Mqa | o3Acl | o3Cam) & stb1)
              | ((o3Mql | o3AnySwp) & stb2);

  assign linkCk = op1 & stb1;

  // CAM loads MQ in phase 2 from an empty bus
  assign mqCk = (o3Mql & stb1)
              | (o3Cam & stb2)
              | (o3AnySwp & stb3);

  assign mq2orbus = ((o3Mqa | o3Acl) & ck1)
                  | (o3AnySwp & ck2);

  // Skip taken at the end of phase 1
  assign pcCk = op2 & stb1 & doSkip;

  // Swap parks old AC in the latch, then returns it in phase 3
  assign mqTmpLatch = o3AnySwp & stb1;
  assign mqTmpOE = o3AnySwp & ck3;

  assign done = (o3Nop & ck1)
              | ((op1 | o3Cla | o3Mqa | o3Acl) & ck2)
              | ((op2 | o3Mql | o3Cam) & ck3)
              | (o3AnySwp & ck4);

  // Sequencer never finishes on a non-OPR word
  doneNeedsOpr: assert property (@(posedge ck) done |-> instOPR);

  // Latch output replaces the bus, so MQ must not be ORed in at the same time
  busSourceExcl: assert property (@(posedge ck) !(mqTmpOE && mq2orbus));

  // Nothing is clocked or finished once the sequence runs into the fault phases
  lateIdle: assert property (@(posedge ck)
    (stb4 || ck5 || stb5 || ck6 || stb6) |->
      !(done || acCk || linkCk || mqCk || pcCk || mqTmpLatch));

endmodule

`default_nettype wire

/* src/oprDatapath.sv */
// AC, link, MQ, MQ temporary latch, PC, OR-bus and group 2 skip test
`timescale 1ns/1ps
`default_nettype none

module oprDatapath import pdp8Pkg::*; (
  input  logic ck,
  input  logic rstN,
  input  logic load,
  input  word_t acIn,
  input  logic linkIn,
  input  word_t mqIn,
  input  word_t pcIn,
  input  logic [g1FieldW-1:0] g1Field,
  input  logic [g2FieldW-1:0] g2Field,
  input  logic acCk,
  input  logic cla,
  input  logic linkCk,
  input  logic mqCk,
  input  logic mq2orbus,
  input  logic pcCk,
  input  logic rot2ac,
  input  logic mqTmpLatch,
  input  logic mqTmpOE,
  input  logic group1Apply,
  output word_t ac,
  output logic link,
  output word_t mq,
  output word_t pc,
  output logic doSkip
);

  word_t mqTmp;
  word_t acBase;
  word_t g1Ac;
  logic g1Link;
  word_t orBus;
  logic skipSma;
  logic skipSza;
  logic skipSnl;
  logic skipRev;
  logic skipAny;

  // CLA zeroes AC ahead of the group 1 logic
  assign acBase = cla ? '0 : ac;

  group1Logic group1Logic_inst (
    .acIn(acBase),
    .linkInBit(link),
    .g1Field(g1Field),
    .apply(group1Apply),
    .acOut(g1Ac),
    .linkOut(g1Link)
  );

  // Bus is empty unless something drives it
  always_comb begin
    orBus = rot2ac ? g1Ac : '0;
    if (mq2orbus) begin
      orBus = orBus | mq;
    end
    // Temporary latch overrides everything else
    if (mqTmpOE) begin
      orBus = mqTmp;
    end
  end

  always_ff @(posedge ck) begin
    if (!rstN) begin
      ac <= '0;
      link <= 1'b0;
      mq <= '0;
      pc <= '0;
    end else if (load) begin
      ac <= acIn;
      link <= linkIn;
      mq <= mqIn;
      pc <= pcIn;
    end else begin
      if (acCk) begin
        ac <= orBus;
      end
      if (linkCk) begin
        link <= g1Link;
      end
      if (mqCk) begin
        mq <= orBus;
      end
      if (pcCk) begin
        pc <= pc + 1'b1;
      end
    end
  end

  // Swap holding register
  always_ff @(posedge ck) begin
    if (mqTmpLatch) begin
      mqTmp <= orBus;
    end
  end

  // Field holds PDP-8 bits 4..8, reverse bit at the bottom
  assign skipSma = g2Field[bitRev-bitSma];
  assign skipSza = g2Field[bitRev-bitSza];
  assign skipSnl = g2Field[bitRev-bitSnl];
  assign skipRev = g2Field[bitRev-bitRev];

  // OR of selected conditions, reverse bit inverts the whole test
  assign skipAny = (skipSma && ac[wordW-1]) || (skipSza && (ac == '0)) || (skipSnl && link);
  assign doSkip = skipRev ? !skipAny : skipAny;

  // Bus feeds one register per strobe
  oneBusLoad: assert property (@(posedge ck) disable iff (!rstN) !(acCk && mqCk));

endmodule

`default_nettype wire

/* src/oprUnit.sv */
// OPR execution unit top level joining sequencer, control decoder and datapath
`timescale 1ns/1ps
`default_nettype none

module oprUnit import pdp8Pkg::*; (
  input  logic ck,
  input  logic rstN,
  input  logic start,
  input  word_t instruction,
  input  logic load,
  input  word_t acIn,
  input  logic linkIn,
  input  word_t mqIn,
  input  word_t pcIn,
  output word_t ac,
  output logic link,
  output word_t mq,
  output word_t pc,
  output logic busy,
  output logic done,
  output logic fault
);

  // Phase levels and strobes
  logic ck1, ck2, ck3, ck4, ck5, ck6;
  logic stb1, stb2, stb3, stb4, stb5, stb6;

  // Decoded instruction fields
  logic instOPR;
  logic opr1;
  logic opr2;
  logic opr3;
  logic oprCLA;
  logic oprMQA;
  logic oprMQL;
  logic oprSCA;
  logic [g1FieldW-1:0] g1Field;
  logic [g2FieldW-1:0] g2Field;

  // Datapath controls
  logic acCk;
  logic cla;
  logic linkCk;
  logic mqCk;
  logic mq2orbus;
  logic pcCk;
  logic rot2ac;
  logic mqTmpLatch;
  logic mqTmpOE;
  logic group1Apply;
  logic doSkip;

  oprSequencer oprSequencer_inst (.*);

  instructionOpr instructionOpr_inst (.*);

  // Register load only while idle
  oprDatapath oprDatapath_inst (
    .load(load && !busy),
    .*
  );

endmodule

`default_nettype wire

/* verification/oprUnitTb.sv */
// Testbench for the OPR unit with reference model, random stimulus and result checks
`timescale 1ns/1ps
`default_nettype none

module oprUnitTb import pdp8Pkg::*; ();

  // Expected outcome of one instruction
  typedef struct packed {
    word_t ac;
    logic link;
    word_t mq;
    word_t pc;
    logic [2:0] k;
    logic fault;
  } result_t;

  localparam int runTimeout = 20;
  localparam int idleTimeout = 20;
  // Sequence runs through stb6 and flags the fault one cycle later
  localparam int faultCycle = 13;

  logic ck;
  logic rstN;
  logic start;
  word_t instruction;
  logic load;
  word_t acIn;
  logic linkIn;
  word_t mqIn;
  word_t pcIn;
  word_t ac;
  logic link;
  word_t mq;
  word_t pc;
  logic busy;
  logic done;
  logic fault;

  int valueErrors;
  int timeoutErrors;

  oprUnit oprUnit_inst (.*);

  always #10 ck = ~ck;

  task automatic compareWord(input string testName, input string what,
                             input word_t expV, input word_t actV);
    if (expV !== actV) begin
      $display("** Error %s %s: expected %04o, actual %04o", testName, what, expV, actV);
      valueErrors++;
    end
  endtask

  task automatic compareBit(input string testName, input string what,
                            input logic expV, input logic actV);
    if (expV !== actV) begin
      $display("** Error %s %s: expected %b, actual %b", testName, what, expV, actV);
      valueErrors++;
    end
  endtask

  task automatic compareCount(input string testName, input int expV, input int actV);
    if (expV != actV) begin
      $display("** Error %s cycles: expected %0d, actual %0d", testName, expV, actV);
      valueErrors++;
    end
  endtask

  // PDP-8 rules for the implemented OPR forms, word bit 11 is PDP-8 bit 0
  function automatic result_t predict(input word_t inst, input word_t acV, input logic linkV,
                                      input word_t mqV, input word_t pcV);
    result_t r;
    logic [wordW:0] lac;
    logic skip;
    r.ac = acV;
    r.link = linkV;
    r.mq = mqV;
    r.pc = pcV;
    r.k = 3'd0;
    r.fault = 1'b0;
    if (inst[11:9] != 3'b111) begin
      // Not an OPR word
      r.fault = 1'b1;
    end else if (!inst[8]) begin
      // Group 1, clears first
      lac = {inst[6] ? 1'b0 : linkV, inst[7] ? word_t'(0) : acV};
      if (inst[5]) begin
        lac[wordW-1:0] = ~lac[wordW-1:0];
      end
      if (inst[4]) begin
        lac[wordW] = ~lac[wordW];
      end
      // 13-bit increment, carry lands in the link
      if (inst[0]) begin
        lac = lac + 13'd1;
      end
      if (inst[3]) begin
        lac = {lac[0], lac[wordW:1]};
        if (inst[1]) begin
          lac = {lac[0], lac[wordW:1]};
        end
      end else if (inst[2]) begin
        lac = {lac[wordW-1:0], lac[wordW]};
        if (inst[1]) begin
          lac = {lac[wordW-1:0], lac[wordW]};
        end
      end
      r.ac = lac[wordW-1:0];
      r.link = lac[wordW];
      r.k = 3'd2;
    end else if (!inst[0]) begin
      // Group 2 tests the old AC, reverse bit flips the OR
      skip = (inst[6] && acV[wordW-1]) || (inst[5] && acV == 0) || (inst[4] && linkV);
      if (inst[3]) begin
        skip = !skip;
      end
      if (skip) begin
        r.pc = pcV + 12'd1;
      end
      if (inst[7]) begin
        r.ac = '0;
      end
      r.k = 3'd3;
    end else if (inst[5]) begin
      // SCA forms are not executed
      r.fault = 1'b1;
    end else begin
      // Group 3 keyed by CLA, MQA, MQL
      case ({inst[7], inst[6], inst[4]})
        3'b000: begin
          r.k = 3'd1;
        end
        3'b100: begin
          r.ac = '0;
          r.k = 3'd2;
        end
        3'b010: begin
          r.ac = acV | mqV;
          r.k = 3'd2;
        end
        3'b110: begin
          r.ac = mqV;
          r.k = 3'd2;
        end
        3'b001: begin
          r.mq = acV;
          r.ac = '0;
          r.k = 3'd3;
        end
        3'b101: begin
          r.ac = '0;
          r.mq = '0;
          r.k = 3'd3;
        end
        3'b011: begin
          r.ac = mqV;
          r.mq = acV;
          r.k = 3'd4;
        end
        default: begin
          r.ac = mqV;
          r.mq = '0;
          r.k = 3'd4;
        end
      endcase
    end
    return r;
  endfunction

  task automatic waitIdle(input string testName);
    int n;
    n = 0;
    while (busy && n < idleTimeout) begin
      @(negedge ck);
      n++;
    end
    if (busy) begin
      $display("Timeout: unit still busy before %s", testName);
      timeoutErrors++;
    end
  endtask

  // Load random registers, run one word, then check every result
  task automatic runTest(input string testName, input word_t inst, input logic disturb);
    word_t acV;
    word_t mqV;
    word_t pcV;
    logic linkV;
    result_t expR;
    int cycles;
    logic finished;
    // Zero AC now and then so SZA gets exercised
    acV = ($urandom_range(3) == 0) ? word_t'(0) : word_t'($urandom);
    linkV = 1'($urandom);
    mqV = word_t'($urandom);
    pcV = word_t'($urandom);
    expR = predict(inst, acV, linkV, mqV, pcV);
    waitIdle(testName);
    @(negedge ck);
    load = 1'b1;
    acIn = acV;
    linkIn = linkV;
    mqIn = mqV;
    pcIn = pcV;
    @(negedge ck);
    load = 1'b0;
    start = 1'b1;
    instruction = inst;
    cycles = 0;
    finished = 1'b0;
    while (!finished && cycles < runTimeout) begin
      @(negedge ck);
      cycles++;
      start = 1'b0;
      load = 1'b0;
      if (done || fault) begin
        finished = 1'b1;
      end
      // Second start and load while busy must both be dropped
      if (disturb && cycles == 1 && !finished) begin
        compareBit(testName, "busy", 1'b1, busy);
        start = 1'b1;
        instruction = 12'o7200;
        load = 1'b1;
        acIn = ~acV;
        linkIn = ~linkV;
        mqIn = ~mqV;
        pcIn = ~pcV;
      end
    end
    start = 1'b0;
    load = 1'b0;
    if (!finished) begin
      $display("Timeout: %s gave neither done nor fault in %0d cycles", testName, runTimeout);
      timeoutErrors++;
    end else begin
      compareCount(testName, expR.fault ? faultCycle : 2 * expR.k - 1, cycles);
      compareBit(testName, "fault", expR.fault, fault);
      compareBit(testName, "done", !expR.fault, done);
      compareWord(testName, "ac", expR.ac, ac);
      compareBit(testName, "link", expR.link, link);
      compareWord(testName, "mq", expR.mq, mq);
      compareWord(testName, "pc", expR.pc, pc);
    end
  endtask

  initial begin
    word_t w;
    logic [7:0] g1Bits;
    logic [4:0] g2Bits;
    logic [2:0] g3Sel;
    ck = 1'b0;
    rstN = 1'b0;
    start = 1'b0;
    instruction = '0;
    load = 1'b0;
    acIn = '0;
    linkIn = 1'b0;
    mqIn = '0;
    pcIn = '0;
    valueErrors = 0;
    timeoutErrors = 0;
    void'($urandom(32'hdf0d9d19));

    // Reset held for 16 cycles, checked before release
    repeat (16) @(posedge ck);
    @(negedge ck);
    compareBit("reset", "busy", 1'b0, busy);
    compareBit("reset", "done", 1'b0, done);
    compareBit("reset", "fault", 1'b0, fault);
    compareWord("reset", "ac", '0, ac);
    compareBit("reset", "link", 1'b0, link);
    compareWord("reset", "mq", '0, mq);
    compareWord("reset", "pc", '0, pc);
    rstN = 1'b1;

    // Group 1, never both rotate bits, twice only with a rotate
    for (int i = 0; i < 40; i++) begin
      g1Bits = 8'($urandom);
      if (g1Bits[3]) begin
        g1Bits[2] = 1'b0;
      end
      if (!g1Bits[3] && !g1Bits[2]) begin
        g1Bits[1] = 1'b0;
      end
      w = {3'b111, 1'b0, g1Bits};
      runTest($sformatf("group1 %04o", w), w, 1'b0);
    end

    // Group 2 with CLA, SMA, SZA, SNL and reverse in bits 4..8
    for (int i = 0; i < 40; i++) begin
      g2Bits = 5'($urandom);
      w = {3'b111, 1'b1, g2Bits, 3'b000};
      runTest($sformatf("group2 %04o", w), w, 1'b0);
    end

    // Every group 3 form twice
    for (int i = 0; i < 16; i++) begin
      g3Sel = 3'(i);
      w = {3'b111, 1'b1, g3Sel[2], g3Sel[1], 1'b0, g3Sel[0], 3'b000, 1'b1};
      runTest($sformatf("group3 %04o", w), w, 1'b0);
    end

    // Opcodes 0..6 and SCA combinations end in fault
    for (int i = 0; i < 7; i++) begin
      w = {3'(i), 9'($urandom)};
      runTest($sformatf("nonOpr %04o", w), w, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      w = {3'b111, 1'b1, 2'($urandom), 1'b1, 1'($urandom), 3'($urandom), 1'b1};
      runTest($sformatf("sca %04o", w), w, 1'b0);
    end

    // Start and load issued while busy
    runTest("busy swp", 12'o7521, 1'b1);
    runTest("busy mql", 12'o7421, 1'b1);
    runTest("busy group1", 12'o7063, 1'b1);
    runTest("busy group2", 12'o7550, 1'b1);
    runTest("busy nonOpr", 12'o1234, 1'b1);

    waitIdle("end of run");
    $display("Checks done: %0d value errors, %0d timeouts", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
src/pdp8Pkg.sv
src/group1Logic.sv
src/oprSequencer.sv
src/instructionOpr.sv
src/oprDatapath.sv
src/oprUnit.sv
verification/oprUnitTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= oprUnitTb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
